// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module clk_ctrl_tb -o clk_ctrl_sim
	./obj_dir/clk_ctrl_sim

clean:
	rm -rf obj_dir

// ==== clock/pll_cfg_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module pll_cfg_sequencer
	import clk_ctrl_pkg::*;
(
	input  wire        clk_sys,
	input  wire        cpu_reset,
	input  wire        pll_locked,
	input  wire        reconfig_start,
	input  speed_t     speed,
	input  uart_mode_t uart_mode,
	output logic       pll_cfg_req,
	output pll_addr_t  pll_cfg_addr,
	output pll_data_t  pll_cfg_data,
	input  wire        pll_cfg_ack,
	output logic       pll_cfg_busy
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQ,
		ST_RELEASE
	} state_t;

	state_t     state;
	logic [1:0] step;
	logic       pending;
	logic       run_go;
	speed_t     speed_q;
	uart_mode_t uart_q;

	assign run_go       = (state == ST_IDLE) && pll_locked && (reconfig_start || pending);
	assign pll_cfg_busy = (state != ST_IDLE);

	// ----------------------------------------------
	// Write contents for each step
	// ----------------------------------------------

	always_comb begin
		case (step)
			2'd0: begin
				pll_cfg_addr = PLL_REG_MODE;
				pll_cfg_data = '0;
			end
			2'd1: begin
				pll_cfg_addr = PLL_REG_COUNTER;
				pll_cfg_data = SPEED_DIV_TABLE[speed_q];
			end
			2'd2: begin
				pll_cfg_addr = PLL_REG_COUNTER;
				case (uart_q)
					2'd0:    pll_cfg_data = UART_DIV_TURBO;
					2'd1:    pll_cfg_data = UART_DIV_NORMAL;
					default: pll_cfg_data = UART_DIV_MIDI;
				endcase
			end
			default: begin
				pll_cfg_addr = PLL_REG_START;
				pll_cfg_data = '0;
			end
		endcase
	end

	// Settings are captured once per run
	always_ff @(posedge clk_sys) begin
		if (run_go) begin
			speed_q <= speed;
			uart_q  <= uart_mode;
		end
	end

	// ----------------------------------------------
	// Four-phase handshake FSM
	// ----------------------------------------------

	always_ff @(posedge clk_sys) begin
		if (cpu_reset) begin
			state       <= ST_IDLE;
			step        <= 2'd0;
			pending     <= 1'b0;
			pll_cfg_req <= 1'b0;
		end else begin
			if (run_go)
				pending <= 1'b0;
			else if (reconfig_start)
				pending <= 1'b1;

			case (state)
				ST_IDLE: begin
					if (run_go) begin
						step        <= 2'd0;
						pll_cfg_req <= 1'b1;
						state       <= ST_REQ;
					end
				end
				ST_REQ: begin
					if (pll_cfg_ack) begin
						pll_cfg_req <= 1'b0;
						state       <= ST_RELEASE;
					end
				end
				default: begin
					// Wait for the manager to drop ack before moving on
					if (!pll_cfg_ack) begin
						if (step == 2'd3) begin
							state <= ST_IDLE;
						end else begin
							step        <= step + 2'd1;
							pll_cfg_req <= 1'b1;
							state       <= ST_REQ;
						end
					end
				end
			endcase
		end
	end

	// Handshake rules seen by the PLL manager
	req_held_until_ack: assert property (
		@(posedge clk_sys) disable iff (cpu_reset)
		$fell(pll_cfg_req) |-> $past(pll_cfg_ack)
	);

	write_stable_during_req: assert property (
		@(posedge clk_sys) disable iff (cpu_reset)
		(pll_cfg_req && $past(pll_cfg_req)) |-> ($stable(pll_cfg_addr) && $stable(pll_cfg_data))
	);

endmodule

`default_nettype wire

// ==== clock/setting_filter.sv ====
`timescale 1ns/1ps
`default_nettype none

module setting_filter #(
	parameter type payload_t = logic
) (
	input  wire      clk_sys,
	input  wire      cpu_reset,
	input  payload_t sample,
	output payload_t value,
	output logic     changed
);

	payload_t stage1;
	payload_t stage2;

	always_ff @(posedge clk_sys) begin
		stage1 <= sample;
		stage2 <= stage1;
		if (cpu_reset) begin
			// Track the input quietly so release does not look like a change
			value   <= stage2;
			changed <= 1'b0;
		end else if ((stage1 == stage2) && (stage2 != value)) begin
			value   <= stage2;
			changed <= 1'b1;
		end else begin
			changed <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== clock/speed_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module speed_decode
	import clk_ctrl_pkg::*;
(
	input  wire        clk_sys,
	input  wire        cpu_reset,
	input  speed_t     speed_req,
	input  wire        midi_rate,
	input  wire        uart_normal,
	output speed_t     speed,
	output uart_mode_t uart_mode,
	output clk_rate_t  clock_rate,
	output logic       reconfig_start
);

	uart_mode_t uart_raw;
	logic       speed_changed;
	logic       uart_changed;
	logic       reset_q;

	// MIDI wins over the normal rate, turbo is the fallback
	always_comb begin
		if (midi_rate)
			uart_raw = 2'd2;
		else if (uart_normal)
			uart_raw = 2'd1;
		else
			uart_raw = 2'd0;
	end

	// ----------------------------------------------
	// Glitch filters
	// ----------------------------------------------

	setting_filter #(
		.payload_t(speed_t)
	) u_speed_filter (
		.clk_sys  (clk_sys),
		.cpu_reset(cpu_reset),
		.sample   (speed_req),
		.value    (speed),
		.changed  (speed_changed)
	);

	setting_filter #(
		.payload_t(uart_mode_t)
	) u_uart_filter (
		.clk_sys  (clk_sys),
		.cpu_reset(cpu_reset),
		.sample   (uart_raw),
		.value    (uart_mode),
		.changed  (uart_changed)
	);

	// Rate figure handed to the CPU timers
	always_ff @(posedge clk_sys) begin
		clock_rate <= CLK_RATE_TABLE[speed];
	end

	// ----------------------------------------------
	// Reconfiguration trigger
	// ----------------------------------------------

	always_ff @(posedge clk_sys) begin
		reset_q <= cpu_reset;
		if (cpu_reset)
			reconfig_start <= 1'b0;
		else
			reconfig_start <= speed_changed | uart_changed | reset_q; // reset_q high only on release
	end

endmodule

`default_nettype wire

// ==== common/clk_ctrl_pkg.sv ====
`default_nettype none

package clk_ctrl_pkg;

	// ----------------------------------------------
	// Setting and PLL types
	// ----------------------------------------------

	// 0..3 select 90/15/30/56.25 MHz, 4..7 select the 100 MHz overclock
	typedef logic [2:0]  speed_t;
	// 0 turbo, 1 normal, 2 MIDI
	typedef logic [1:0]  uart_mode_t;
	typedef logic [27:0] clk_rate_t;
	typedef logic [5:0]  pll_addr_t;
	typedef logic [31:0] pll_data_t;

	// ----------------------------------------------
	// Framebuffer types
	// ----------------------------------------------

	// [1:0] colour mode, [2] quarter width, [3] line doubling
	typedef logic [3:0]  vga_flags_t;
	typedef logic [11:0] fb_width_t;
	typedef logic [11:0] fb_height_t;
	typedef logic [13:0] fb_stride_t;
	typedef logic [4:0]  fb_format_t;
	typedef logic [31:0] fb_base_t;

	// CPU clock in Hz for each speed index
	localparam clk_rate_t CLK_RATE_TABLE [8] = '{
		28'd90000000, 28'd15000000, 28'd30000000, 28'd56250000,
		28'd100000000, 28'd100000000, 28'd100000000, 28'd100000000
	};

	// PLL counter words for the CPU clock output
	localparam pll_data_t SPEED_DIV_TABLE [8] = '{
		32'h0000_0505, 32'h0000_1E1E, 32'h0000_0F0F, 32'h0000_0808,
		32'h0002_0504, 32'h0002_0504, 32'h0002_0504, 32'h0002_0504
	};

	localparam pll_data_t UART_DIV_TURBO  = 32'h0004_0909;
	localparam pll_data_t UART_DIV_NORMAL = 32'h0004_F4F4;
	localparam pll_data_t UART_DIV_MIDI   = 32'h0004_9696;

	// Reconfiguration register map
	localparam pll_addr_t PLL_REG_MODE    = 6'd0;
	localparam pll_addr_t PLL_REG_COUNTER = 6'd5;
	localparam pll_addr_t PLL_REG_START   = 6'd2;

	localparam fb_base_t  FB_BASE_OFFSET     = 32'h3F80_0000;
	localparam fb_width_t FB_WIDE_LIMIT      = 12'd760;
	localparam fb_width_t FB_TRUECOLOR_WIDTH = 12'd640;

	// Roughly 50 ms of light at the system clock
	localparam int LED_HOLD_DEFAULT = 4500000;

endpackage

`default_nettype wire

// ==== files.f ====
common/clk_ctrl_pkg.sv
clock/setting_filter.sv
clock/speed_decode.sv
clock/pll_cfg_sequencer.sv
hdl/fb_descriptor.sv
hdl/activity_led.sv
hdl/clk_ctrl_top.sv
sim/clk_ctrl_tb.sv

// ==== hdl/activity_led.sv ====
`timescale 1ns/1ps
`default_nettype none

module activity_led #(
	parameter int req_width   = 1,
	parameter int hold_cycles = 1000
) (
	input  wire                 clk_sys,
	input  wire                 cpu_reset,
	input  wire [req_width-1:0] req,
	output logic                led
);

	localparam int CNT_W = $clog2(hold_cycles + 1);

	logic [CNT_W-1:0] hold_cnt;

	// Any request restarts the full hold time
	always_ff @(posedge clk_sys) begin
		if (cpu_reset)
			hold_cnt <= '0;
		else if (|req)
			hold_cnt <= CNT_W'(hold_cycles);
		else if (hold_cnt != '0)
			hold_cnt <= hold_cnt - 1'b1;
	end

	assign led = (hold_cnt != '0);

endmodule

`default_nettype wire

// ==== hdl/clk_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module clk_ctrl_top
	import clk_ctrl_pkg::*;
#(
	parameter int led_hold_cycles = LED_HOLD_DEFAULT
) (
	input  wire         clk_sys,
	input  wire         cpu_reset,
	input  speed_t      speed_req,
	input  wire         midi_rate,
	input  wire         uart_normal,
	input  wire         pll_locked,
	input  wire         pll_cfg_ack,
	output logic        pll_cfg_req,
	output pll_addr_t   pll_cfg_addr,
	output pll_data_t   pll_cfg_data,
	output logic        pll_cfg_busy,
	output clk_rate_t   clock_rate,
	input  vga_flags_t  vga_flags,
	input  wire  [19:0] vga_start_addr,
	input  wire  [8:0]  vga_width,
	input  wire  [8:0]  vga_stride,
	input  wire  [10:0] vga_height,
	input  wire         rgb_order,
	input  wire         fmt_565,
	input  wire         vsync_variable,
	output logic        fb_en,
	output fb_base_t    fb_base,
	output fb_width_t   fb_width,
	output fb_height_t  fb_height,
	output fb_stride_t  fb_stride,
	output fb_format_t  fb_format,
	output logic        video_f60,
	input  wire  [5:0]  hdd_req,
	input  wire  [1:0]  fdd_req,
	output logic        hdd_led,
	output logic        fdd_led
);

	speed_t     speed;
	uart_mode_t uart_mode;
	logic       reconfig_start;

	// ----------------------------------------------
	// CPU clock selection
	// ----------------------------------------------

	speed_decode u_speed_decode (
		.clk_sys       (clk_sys),
		.cpu_reset     (cpu_reset),
		.speed_req     (speed_req),
		.midi_rate     (midi_rate),
		.uart_normal   (uart_normal),
		.speed         (speed),
		.uart_mode     (uart_mode),
		.clock_rate    (clock_rate),
		.reconfig_start(reconfig_start)
	);

	pll_cfg_sequencer u_pll_cfg_sequencer (
		.clk_sys       (clk_sys),
		.cpu_reset     (cpu_reset),
		.pll_locked    (pll_locked),
		.reconfig_start(reconfig_start),
		.speed         (speed),
		.uart_mode     (uart_mode),
		.pll_cfg_req   (pll_cfg_req),
		.pll_cfg_addr  (pll_cfg_addr),
		.pll_cfg_data  (pll_cfg_data),
		.pll_cfg_ack   (pll_cfg_ack),
		.pll_cfg_busy  (pll_cfg_busy)
	);

	// ----------------------------------------------
	// Video and front panel
	// ----------------------------------------------

	fb_descriptor u_fb_descriptor (
		.clk_sys       (clk_sys),
		.cpu_reset     (cpu_reset),
		.vga_flags     (vga_flags),
		.vga_start_addr(vga_start_addr),
		.vga_width     (vga_width),
		.vga_stride    (vga_stride),
		.vga_height    (vga_height),
		.rgb_order     (rgb_order),
		.fmt_565       (fmt_565),
		.vsync_variable(vsync_variable),
		.fb_en         (fb_en),
		.fb_base       (fb_base),
		.fb_width      (fb_width),
		.fb_height     (fb_height),
		.fb_stride     (fb_stride),
		.fb_format     (fb_format),
		.video_f60     (video_f60)
	);

	activity_led #(
		.req_width  (6),
		.hold_cycles(led_hold_cycles)
	) u_hdd_led (
		.clk_sys  (clk_sys),
		.cpu_reset(cpu_reset),
		.req      (hdd_req),
		.led      (hdd_led)
	);

	activity_led #(
		.req_width  (2),
		.hold_cycles(led_hold_cycles)
	) u_fdd_led (
		.clk_sys  (clk_sys),
		.cpu_reset(cpu_reset),
		.req      (fdd_req),
		.led      (fdd_led)
	);

endmodule

`default_nettype wire

// ==== hdl/fb_descriptor.sv ====
`timescale 1ns/1ps
`default_nettype none

module fb_descriptor
	import clk_ctrl_pkg::*;
(
	input  wire         clk_sys,
	input  wire         cpu_reset,
	input  vga_flags_t  vga_flags,
	input  wire  [19:0] vga_start_addr,
	input  wire  [8:0]  vga_width,
	input  wire  [8:0]  vga_stride,
	input  wire  [10:0] vga_height,
	input  wire         rgb_order,
	input  wire         fmt_565,
	input  wire         vsync_variable,
	output logic        fb_en,
	output fb_base_t    fb_base,
	output fb_width_t   fb_width,
	output fb_height_t  fb_height,
	output fb_stride_t  fb_stride,
	output fb_format_t  fb_format,
	output logic        video_f60
);

	logic [1:0] colour_mode;
	logic       vsync_var_q;

	assign colour_mode = vga_flags[1:0];

	// Scanout only for packed pixel modes at full width
	always_ff @(posedge clk_sys) begin
		if (cpu_reset)
			fb_en <= 1'b0;
		else
			fb_en <= !vga_flags[2] && (colour_mode != 2'd0);
	end

	// ----------------------------------------------
	// Geometry and pixel format
	// ----------------------------------------------

	always_ff @(posedge clk_sys) begin
		fb_base   <= FB_BASE_OFFSET + {10'd0, vga_start_addr, 2'b00};
		fb_stride <= {2'b00, vga_stride, 3'b000};

		if (colour_mode == 2'd3)
			fb_width <= FB_TRUECOLOR_WIDTH;
		else if (vga_flags[2])
			fb_width <= {1'b0, vga_width, 2'b00};
		else
			fb_width <= {vga_width, 3'b000};

		// Doubled lines are stored once
		if (vga_flags[3])
			fb_height <= {2'b00, vga_height[10:1]};
		else
			fb_height <= {1'b0, vga_height};

		// 5 is 24 bpp, 4 is 16 bpp, 3 is 8 bpp palette
		case (colour_mode)
			2'd3:    fb_format[2:0] <= 3'd5;
			2'd2:    fb_format[2:0] <= 3'd4;
			default: fb_format[2:0] <= 3'd3;
		endcase
		fb_format[4] <= ~rgb_order;
		fb_format[3] <= ~fmt_565;

		vsync_var_q <= vsync_variable;
	end

	// Force 60 Hz when the output would not fit a variable refresh
	always_ff @(posedge clk_sys) begin
		video_f60 <= !vsync_var_q || fb_en || (fb_width > FB_WIDE_LIMIT);
	end

endmodule

`default_nettype wire

// ==== sim/clk_ctrl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module clk_ctrl_tb
	import clk_ctrl_pkg::*;
();

	localparam int NUM_ROWS = 6;

	typedef struct packed {
		speed_t      speed;
		logic        midi;
		logic        normal;
		vga_flags_t  flags;
		logic [19:0] start;
		logic [8:0]  width;
		logic [8:0]  stride;
		logic [10:0] height;
		logic        rgb_order;
		logic        fmt_565;
		logic        vsync_var;
	} row_t;

	logic        clk_sys;
	logic        cpu_reset;
	speed_t      speed_req;
	logic        midi_rate;
	logic        uart_normal;
	logic        pll_locked;
	logic        pll_cfg_ack;
	logic        pll_cfg_req;
	pll_addr_t   pll_cfg_addr;
	pll_data_t   pll_cfg_data;
	logic        pll_cfg_busy;
	clk_rate_t   clock_rate;
	vga_flags_t  vga_flags;
	logic [19:0] vga_start_addr;
	logic [8:0]  vga_width;
	logic [8:0]  vga_stride;
	logic [10:0] vga_height;
	logic        rgb_order;
	logic        fmt_565;
	logic        vsync_variable;
	logic        fb_en;
	fb_base_t    fb_base;
	fb_width_t   fb_width;
	fb_height_t  fb_height;
	fb_stride_t  fb_stride;
	fb_format_t  fb_format;
	logic        video_f60;
	logic [5:0]  hdd_req;
	logic [1:0]  fdd_req;
	logic        hdd_led;
	logic        fdd_led;

	// Every write seen on the PLL port, in arrival order
	pll_addr_t   write_addr_log [$];
	pll_data_t   write_data_log [$];
	int          writes_checked = 0;
	logic [31:0] lcg_state = 32'd32;

	clk_ctrl_top #(
		.led_hold_cycles(40)
	) dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// --------------------------------------------------
	// Reference helpers and compare tasks
	// --------------------------------------------------

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int unsigned ack_delay();
		logic [31:0] r;
		r = lcg_next();
		return 1 + ((r >> 16) % 8);
	endfunction

	function automatic uart_mode_t expected_uart_mode(input logic midi, input logic normal);
		if (midi)
			return 2'd2;
		return normal ? 2'd1 : 2'd0;
	endfunction

	function automatic pll_data_t uart_divider(input uart_mode_t mode);
		if (mode == 2'd0)
			return UART_DIV_TURBO;
		if (mode == 2'd1)
			return UART_DIV_NORMAL;
		return UART_DIV_MIDI;
	endfunction

	// Columns: speed, midi, normal, flags, start, width, stride, height, rgb, 565, vsync var
	function automatic row_t stimulus_row(input int i);
		row_t r;
		case (i)
			0: r = '{3'd2, 1'b0, 1'b1, 4'b0011, 20'h01000, 9'd80, 9'd240, 11'd480, 1'b0, 1'b0, 1'b1};
			1: r = '{3'd1, 1'b0, 1'b0, 4'b0010, 20'h00000, 9'd100, 9'd200, 11'd600, 1'b1, 1'b1, 1'b1};
			2: r = '{3'd3, 1'b1, 1'b0, 4'b1000, 20'h12345, 9'd90, 9'd90, 11'd800, 1'b0, 1'b1, 1'b1};
			3: r = '{3'd5, 1'b0, 1'b1, 4'b0110, 20'hABCDE, 9'd200, 9'd50, 11'd401, 1'b1, 1'b0, 1'b1};
			4: r = '{3'd0, 1'b1, 1'b1, 4'b1001, 20'hFFFFF, 9'd511, 9'd511, 11'd2047, 1'b0, 1'b0, 1'b0};
			default: r = '{3'd7, 1'b0, 1'b0, 4'b0101, 20'h00400, 9'd160, 9'd80, 11'd350, 1'b1, 1'b1, 1'b1};
		endcase
		return r;
	endfunction

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("test failed");
		$fatal(1, "stopping on first error");
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_with_failure($sformatf("CHECK FAILED at %0t: %s is %b, expected %b",
				$time, name, got, exp));
	endtask

	task automatic check_rate(input clk_rate_t exp);
		if (clock_rate !== exp)
			stop_with_failure($sformatf("CHECK FAILED at %0t: clock_rate is %0d, expected %0d",
				$time, clock_rate, exp));
	endtask

	task automatic check_write(input int idx, input pll_addr_t exp_addr, input pll_data_t exp_data);
		if (write_addr_log[idx] !== exp_addr)
			stop_with_failure($sformatf(
				"CHECK FAILED at %0t: pll_cfg_addr of write %0d is %0h, expected %0h",
				$time, idx, write_addr_log[idx], exp_addr));
		if (write_data_log[idx] !== exp_data)
			stop_with_failure($sformatf(
				"CHECK FAILED at %0t: pll_cfg_data of write %0d is %0h, expected %0h",
				$time, idx, write_data_log[idx], exp_data));
	endtask

	task automatic check_fb(input fb_base_t base, input fb_width_t width,
			input fb_height_t height, input fb_stride_t stride, input fb_format_t format);
		if (fb_base !== base)
			stop_with_failure($sformatf("CHECK FAILED at %0t: fb_base is %0h, expected %0h",
				$time, fb_base, base));
		if (fb_width !== width)
			stop_with_failure($sformatf("CHECK FAILED at %0t: fb_width is %0h, expected %0h",
				$time, fb_width, width));
		if (fb_height !== height)
			stop_with_failure($sformatf("CHECK FAILED at %0t: fb_height is %0h, expected %0h",
				$time, fb_height, height));
		if (fb_stride !== stride)
			stop_with_failure($sformatf("CHECK FAILED at %0t: fb_stride is %0h, expected %0h",
				$time, fb_stride, stride));
		if (fb_format !== format)
			stop_with_failure($sformatf("CHECK FAILED at %0t: fb_format is %0h, expected %0h",
				$time, fb_format, format));
	endtask

	// Descriptor rules worked out from the VGA mode of one row
	task automatic check_descriptor(input row_t r);
		logic       en;
		fb_width_t  w;
		fb_height_t h;
		fb_format_t fmt;
		en = !r.flags[2] && (r.flags[1:0] != 2'd0);
		if (r.flags[1:0] == 2'd3)
			w = FB_TRUECOLOR_WIDTH;
		else if (r.flags[2])
			w = fb_width_t'(r.width) * 12'd4;
		else
			w = fb_width_t'(r.width) * 12'd8;
		h = r.flags[3] ? fb_height_t'(r.height) / 12'd2 : fb_height_t'(r.height);
		fmt = {~r.rgb_order, ~r.fmt_565, 3'd3};
		if (r.flags[1:0] == 2'd3)
			fmt[2:0] = 3'd5;
		else if (r.flags[1:0] == 2'd2)
			fmt[2:0] = 3'd4;
		check_bit("fb_en", fb_en, en);
		check_fb(FB_BASE_OFFSET + fb_base_t'(r.start) * 32'd4, w, h,
			fb_stride_t'(r.stride) * 14'd8, fmt);
		check_bit("video_f60", video_f60, !r.vsync_var || en || (w > FB_WIDE_LIMIT));
	endtask

	// Mode, counter, counter, start
	task automatic check_sequence(input speed_t spd, input uart_mode_t mode);
		check_write(writes_checked, PLL_REG_MODE, 32'd0);
		check_write(writes_checked + 1, PLL_REG_COUNTER, SPEED_DIV_TABLE[spd]);
		check_write(writes_checked + 2, PLL_REG_COUNTER, uart_divider(mode));
		check_write(writes_checked + 3, PLL_REG_START, 32'd0);
		writes_checked += 4;
	endtask

	task automatic wait_for_sequences(input int count);
		int target;
		target = writes_checked + 4 * count;
		while (write_addr_log.size() < target)
			@(posedge clk_sys);
		while (pll_cfg_busy)
			@(posedge clk_sys);
		check_bit("pll_cfg_ack", pll_cfg_ack, 1'b0);
	endtask

	task automatic expect_no_writes(input int cycles);
		repeat (cycles) @(posedge clk_sys);
		if (write_addr_log.size() != writes_checked)
			stop_with_failure($sformatf("PLL port got %0d writes that no setting change asked for",
				write_addr_log.size() - writes_checked));
	endtask

	task automatic apply_row(input row_t r);
		@(posedge clk_sys);
		speed_req      <= r.speed;
		midi_rate      <= r.midi;
		uart_normal    <= r.normal;
		vga_flags      <= r.flags;
		vga_start_addr <= r.start;
		vga_width      <= r.width;
		vga_stride     <= r.stride;
		vga_height     <= r.height;
		rgb_order      <= r.rgb_order;
		fmt_565        <= r.fmt_565;
		vsync_variable <= r.vsync_var;
	endtask

	// --------------------------------------------------
	// PLL manager model and watchdog
	// --------------------------------------------------

	initial begin : pll_responder
		int unsigned delay;
		pll_cfg_ack <= 1'b0;
		forever begin
			@(posedge clk_sys);
			if (pll_cfg_req && !pll_cfg_ack) begin
				delay = ack_delay();
				repeat (delay - 1) @(posedge clk_sys);
				write_addr_log.push_back(pll_cfg_addr);
				write_data_log.push_back(pll_cfg_data);
				pll_cfg_ack <= 1'b1;
				do
					@(posedge clk_sys);
				while (pll_cfg_req);
				pll_cfg_ack <= 1'b0;
			end
		end
	end

	initial begin : watchdog
		repeat (NUM_ROWS * 400) @(posedge clk_sys);
		stop_with_failure("Watchdog expired before all tests completed");
	end

	// --------------------------------------------------
	// Test sequence
	// --------------------------------------------------

	initial begin
		row_t row;
		cpu_reset      <= 1'b1;
		speed_req      <= 3'd0;
		midi_rate      <= 1'b0;
		uart_normal    <= 1'b1;
		pll_locked     <= 1'b1;
		vga_flags      <= '0;
		vga_start_addr <= '0;
		vga_width      <= '0;
		vga_stride     <= '0;
		vga_height     <= '0;
		rgb_order      <= 1'b0;
		fmt_565        <= 1'b0;
		vsync_variable <= 1'b0;
		hdd_req        <= '0;
		fdd_req        <= '0;

		repeat (5) @(posedge clk_sys);
		check_bit("pll_cfg_req", pll_cfg_req, 1'b0);
		check_bit("pll_cfg_busy", pll_cfg_busy, 1'b0);
		check_bit("fb_en", fb_en, 1'b0);
		check_bit("hdd_led", hdd_led, 1'b0);
		check_bit("fdd_led", fdd_led, 1'b0);
		repeat (5) @(posedge clk_sys);
		cpu_reset <= 1'b0;

		// Release of reset programs the initial settings
		wait_for_sequences(1);
		check_sequence(3'd0, expected_uart_mode(1'b0, 1'b1));
		expect_no_writes(10);

		for (int i = 0; i < NUM_ROWS; i++) begin
			row = stimulus_row(i);
			apply_row(row);
			repeat (3) @(posedge clk_sys);
			check_descriptor(row);
			wait_for_sequences(1);
			check_sequence(row.speed, expected_uart_mode(row.midi, row.normal));
			expect_no_writes(10);
			check_rate(CLK_RATE_TABLE[row.speed]);
		end

		// UART mode alone, then a speed glitch that must be ignored
		@(posedge clk_sys);
		uart_normal <= 1'b1;
		wait_for_sequences(1);
		check_sequence(3'd7, expected_uart_mode(1'b0, 1'b1));
		expect_no_writes(10);
		@(posedge clk_sys);
		speed_req <= 3'd3;
		@(posedge clk_sys);
		speed_req <= 3'd7;
		expect_no_writes(20);
		check_rate(CLK_RATE_TABLE[7]);

		// Second change lands while the first run is still busy
		@(posedge clk_sys);
		speed_req <= 3'd1;
		while (!pll_cfg_busy)
			@(posedge clk_sys);
		@(posedge clk_sys);
		speed_req <= 3'd2;
		wait_for_sequences(2);
		check_sequence(3'd1, 2'd1);
		check_sequence(3'd2, 2'd1);
		expect_no_writes(10);
		check_rate(CLK_RATE_TABLE[2]);

		// A change while the PLL is unlocked waits for lock
		@(posedge clk_sys);
		pll_locked <= 1'b0;
		speed_req  <= 3'd4;
		expect_no_writes(20);
		check_bit("pll_cfg_busy", pll_cfg_busy, 1'b0);
		@(posedge clk_sys);
		pll_locked <= 1'b1;
		wait_for_sequences(1);
		check_sequence(3'd4, 2'd1);
		expect_no_writes(10);
		check_rate(CLK_RATE_TABLE[4]);

		// Activity lights from single-cycle pulses
		@(posedge clk_sys);
		hdd_req <= 6'b001000;
		fdd_req <= 2'b10;
		@(posedge clk_sys);
		hdd_req <= '0;
		fdd_req <= '0;
		@(posedge clk_sys);
		check_bit("hdd_led", hdd_led, 1'b1);
		check_bit("fdd_led", fdd_led, 1'b1);
		repeat (29) @(posedge clk_sys);
		check_bit("hdd_led", hdd_led, 1'b1);
		check_bit("fdd_led", fdd_led, 1'b1);
		repeat (14) @(posedge clk_sys);
		check_bit("hdd_led", hdd_led, 1'b0);
		check_bit("fdd_led", fdd_led, 1'b0);

		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire
